// File: source/adc_pkg.sv
/*
  Flash ADC shared types
*/
package adc_pkg;

  // Width of one analog sample word
  localparam int VIN_BITS = 10;

  // Widest converter resolution that the code type can hold
  localparam int MAX_CODE_BITS = 6;

  // Wide enough for 16 samples of the largest code
  localparam int ACC_BITS = 16;

  typedef logic [VIN_BITS-1:0] vin_t;
  typedef logic [MAX_CODE_BITS-1:0] code_t;
  typedef logic [ACC_BITS-1:0] acc_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SETTLE,
    S_ENCODE,
    S_ACCUM,
    S_OUTPUT
  } seq_state_t;

  // One averaged result as it leaves on the output stream
  typedef struct packed {
    code_t code;
    logic  overrange;
  } adc_result_t;

endpackage

// File: source/adc_comparator_bank.sv
/*
  Reference ladder and comparators
*/
`timescale 1ns/1ps

module adc_comparator_bank import adc_pkg::*; #(
  parameter int CODE_BITS = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      sample_en,
  input  vin_t                      vin,
  output logic [2**CODE_BITS-2:0]   thermo
);

  localparam int N     = 2**CODE_BITS - 1;
  localparam int SHIFT = VIN_BITS - CODE_BITS;

  logic [N-1:0] hit;

  // Evenly spaced ladder, tap i sits at (i+1) LSBs of the output code
  for (genvar i = 0; i < N; i++)
  begin : g_cmp
    localparam vin_t THRESH = vin_t'((i + 1) << SHIFT);
    assign hit[i] = (vin >= THRESH);
  end

  // The row is only sampled on an accepted input beat
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      thermo <= '0;
    end
    else if (sample_en)
    begin
      thermo <= hit;
    end
  end

  // A captured code must be a solid run of ones from bit 0 that matches the sample
  a_thermo_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    sample_en |=> ((thermo & (thermo + 1'b1)) == '0) &&
                  ($countones(thermo) == int'($past(vin) >> SHIFT))
  );

endmodule

// File: source/adc_thermo_encoder.sv
/*
  Thermometer to binary encoder
*/
`timescale 1ns/1ps

module adc_thermo_encoder import adc_pkg::*; #(
  parameter int CODE_BITS = 3
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      encode_en,
  input  logic [2**CODE_BITS-2:0]   thermo,
  output code_t                     code,
  output logic                      full_scale
);

  localparam int N = 2**CODE_BITS - 1;

  code_t ones;

  // Position of the highest set tap plus one, zero when no tap is set
  function automatic code_t top_bit_plus_one(input logic [N-1:0] t);
    code_t pos;
    pos = '0;
    for (int i = 0; i < N; i++)
    begin
      if (t[i])
        pos = code_t'(i + 1);
    end
    return pos;
  endfunction

  always_comb
  begin
    ones = '0;
    for (int i = 0; i < N; i++)
      ones = ones + code_t'(thermo[i]);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      code       <= '0;
      full_scale <= 1'b0;
    end
    else if (encode_en)
    begin
      code       <= ones;
      full_scale <= &thermo;
    end
  end

  a_code_matches_top: assert property (
    @(posedge clk) disable iff (!rst_n)
    encode_en |=> code == $past(top_bit_plus_one(thermo))
  );

  // Outputs only move on an encode strobe
  a_code_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    !encode_en |=> $stable(code) && $stable(full_scale)
  );

endmodule

// File: source/adc_settle_timer.sv
/*
  Settle and group counters
*/
`timescale 1ns/1ps

module adc_settle_timer #(
  parameter int SETTLE_CYCLES = 3,
  parameter int AVG_LOG2      = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic timer_load,
  input  logic group_load,
  input  logic sample_done,
  output logic settle_done,
  output logic group_last
);

  localparam int SW = (SETTLE_CYCLES > 1) ? $clog2(SETTLE_CYCLES) : 1;
  localparam int GW = (AVG_LOG2 > 0) ? AVG_LOG2 : 1;

  logic [SW-1:0] settle_cnt;
  logic [GW-1:0] group_cnt;

  // Loaded at the accept edge so that it reaches zero in the last settle cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      settle_cnt <= '0;
    else if (timer_load)
      settle_cnt <= SW'(SETTLE_CYCLES - 1);
    else if (settle_cnt != '0)
      settle_cnt <= settle_cnt - 1'b1;
  end

  // Samples left in the group, reloaded when a result has been taken
  always_ff @(posedge clk)
  begin
    if (!rst_n || group_load)
      group_cnt <= GW'((1 << AVG_LOG2) - 1);
    else if (sample_done && group_cnt != '0)
      group_cnt <= group_cnt - 1'b1;
  end

  assign settle_done = (settle_cnt == '0);
  assign group_last  = (group_cnt == '0);

endmodule

// File: source/adc_sequencer.sv
/*
  Conversion sequencer
*/
`timescale 1ns/1ps

module adc_sequencer import adc_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic vin_valid,
  output logic vin_ready,
  input  logic res_ready,
  output logic res_valid,
  output logic sample_en,
  output logic timer_load,
  output logic group_load,
  output logic encode_en,
  output logic acc_clear,
  output logic acc_add,
  input  logic settle_done,
  input  logic group_last
);

  seq_state_t state;
  seq_state_t state_next;

  logic in_fire;
  logic out_fire;

  assign in_fire  = vin_valid && vin_ready;
  assign out_fire = res_valid && res_ready;

  always_comb
  begin
    state_next = state;
    case (state)
      S_IDLE:   if (in_fire) state_next = S_SETTLE;
      S_SETTLE: if (settle_done) state_next = S_ENCODE;
      S_ENCODE: state_next = S_ACCUM;
      S_ACCUM:  state_next = group_last ? S_OUTPUT : S_IDLE;
      S_OUTPUT: if (out_fire) state_next = S_IDLE;
      default:  state_next = S_IDLE;
    endcase
  end

  // Handshake outputs are registered so both are low for the first cycle after reset
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      vin_ready <= 1'b0;
      res_valid <= 1'b0;
    end
    else
    begin
      state     <= state_next;
      vin_ready <= (state_next == S_IDLE);
      res_valid <= (state_next == S_OUTPUT);
    end
  end

  assign sample_en  = in_fire;
  assign timer_load = in_fire;
  assign encode_en  = (state == S_ENCODE);
  assign acc_add    = (state == S_ACCUM);
  // Taking the result starts a fresh group
  assign acc_clear  = out_fire;
  assign group_load = out_fire;

  a_one_stream: assert property (
    @(posedge clk) disable iff (!rst_n) !(vin_ready && res_valid)
  );

  a_res_hold: assert property (
    @(posedge clk) disable iff (!rst_n) res_valid && !res_ready |=> res_valid
  );

endmodule

// File: source/adc_accumulator.sv
/*
  Averaging accumulator
*/
`timescale 1ns/1ps

module adc_accumulator import adc_pkg::*; #(
  parameter int CODE_BITS = 3,
  parameter int AVG_LOG2  = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        acc_clear,
  input  logic        acc_add,
  input  code_t       code,
  input  logic        full_scale,
  output adc_result_t res
);

  // Largest sum one group can reach
  localparam int MAX_SUM = (2**AVG_LOG2) * (2**CODE_BITS - 1);

  acc_t sum;
  logic overrange;

  always_ff @(posedge clk)
  begin
    if (!rst_n || acc_clear)
    begin
      sum       <= '0;
      overrange <= 1'b0;
    end
    else if (acc_add)
    begin
      sum       <= sum + acc_t'(code);
      overrange <= overrange | full_scale;
    end
  end

  // Dividing by the group size truncates toward zero
  assign res.code      = code_t'(sum >> AVG_LOG2);
  assign res.overrange = overrange;

  a_sum_bound: assert property (
    @(posedge clk) disable iff (!rst_n) sum <= acc_t'(MAX_SUM)
  );

endmodule

// File: source/adc_flash_top.sv
/*
  Flash ADC back end top level
*/
`timescale 1ns/1ps

module adc_flash_top import adc_pkg::*; #(
  parameter int CODE_BITS     = 3,
  parameter int SETTLE_CYCLES = 3,
  parameter int AVG_LOG2      = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        vin_valid,
  output logic        vin_ready,
  input  vin_t        vin,
  output logic        res_valid,
  input  logic        res_ready,
  output adc_result_t res
);

  logic [2**CODE_BITS-2:0] thermo;
  code_t                   code;
  logic                    full_scale;

  logic sample_en;
  logic timer_load;
  logic group_load;
  logic encode_en;
  logic acc_clear;
  logic acc_add;
  logic settle_done;
  logic group_last;

  adc_sequencer i_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .vin_valid   (vin_valid),
    .vin_ready   (vin_ready),
    .res_ready   (res_ready),
    .res_valid   (res_valid),
    .sample_en   (sample_en),
    .timer_load  (timer_load),
    .group_load  (group_load),
    .encode_en   (encode_en),
    .acc_clear   (acc_clear),
    .acc_add     (acc_add),
    .settle_done (settle_done),
    .group_last  (group_last)
  );

  adc_comparator_bank #(.CODE_BITS(CODE_BITS)) i_cmp (
    .clk       (clk),
    .rst_n     (rst_n),
    .sample_en (sample_en),
    .vin       (vin),
    .thermo    (thermo)
  );

  adc_thermo_encoder #(.CODE_BITS(CODE_BITS)) i_enc (
    .clk        (clk),
    .rst_n      (rst_n),
    .encode_en  (encode_en),
    .thermo     (thermo),
    .code       (code),
    .full_scale (full_scale)
  );

  // Each add closes one sample of the group
  adc_settle_timer #(.SETTLE_CYCLES(SETTLE_CYCLES), .AVG_LOG2(AVG_LOG2)) i_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .timer_load  (timer_load),
    .group_load  (group_load),
    .sample_done (acc_add),
    .settle_done (settle_done),
    .group_last  (group_last)
  );

  adc_accumulator #(.CODE_BITS(CODE_BITS), .AVG_LOG2(AVG_LOG2)) i_acc (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc_clear  (acc_clear),
    .acc_add    (acc_add),
    .code       (code),
    .full_scale (full_scale),
    .res        (res)
  );

endmodule

// File: verif/tb_adc_flash.sv
/*
  Flash ADC back end testbench
*/
`timescale 1ns/1ps

module tb_adc_flash import adc_pkg::*; ();

  localparam int CODE_BITS     = 3;
  localparam int SETTLE_CYCLES = 3;
  localparam int AVG_LOG2      = 2;
  localparam int GROUP         = 2**AVG_LOG2;
  localparam int SHIFT         = VIN_BITS - CODE_BITS;
  localparam int MAX_CODE      = 2**CODE_BITS - 1;
  localparam int NUM_GROUPS    = 200;
  // Each sample needs about SETTLE_CYCLES plus four cycles, times four for gaps and stalls
  localparam int CYCLE_LIMIT   = NUM_GROUPS * (GROUP * (SETTLE_CYCLES + 4) + 2) * 4;

  logic        clk;
  logic        rst_n;
  logic        vin_valid;
  logic        vin_ready;
  vin_t        vin;
  logic        res_valid;
  logic        res_ready;
  adc_result_t res;

  logic [31:0] lcg_state;
  vin_t        directed_q[$];
  vin_t        model_q[$];
  int          cycles;
  int          groups_done;
  logic        in_fire;
  logic        out_fire;
  logic        held_valid;
  adc_result_t held_res;
  adc_result_t exp_res;
  logic [31:0] r;

  adc_flash_top #(
    .CODE_BITS     (CODE_BITS),
    .SETTLE_CYCLES (SETTLE_CYCLES),
    .AVG_LOG2      (AVG_LOG2)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .vin_valid (vin_valid),
    .vin_ready (vin_ready),
    .vin       (vin),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Average of the oldest group in the model, built from the ladder rules
  function automatic adc_result_t model_result();
    int          sum;
    int          c;
    adc_result_t m;
    sum = 0;
    m   = '0;
    for (int i = 0; i < GROUP; i++)
    begin
      c   = int'(model_q[i]) >> SHIFT;
      sum = sum + c;
      if (c == MAX_CODE)
        m.overrange = 1'b1;
    end
    m.code = code_t'(sum / GROUP);
    return m;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, actual, expected));
  endtask

  // Picks the next sample, directed edge cases first
  function automatic vin_t pick_sample();
    logic [31:0] s;
    if (directed_q.size() > 0)
      return directed_q.pop_front();
    s = next_rand();
    case (s[31:29])
      3'd0:       return '1;
      3'd1:       return '0;
      3'd2, 3'd3: return {s[28:26], 7'd0};
      default:    return s[25:16];
    endcase
  endfunction

  initial
  begin
    lcg_state   = 32'h3a2fed4f;
    rst_n       = 1'b0;
    vin_valid   = 1'b0;
    vin         = '0;
    res_ready   = 1'b0;
    cycles      = 0;
    groups_done = 0;
    held_valid  = 1'b0;
    held_res    = '0;
    in_fire     = 1'b0;
    out_fire    = 1'b0;

    // Each directed group repeats one sample that sits on a threshold or one step below it
    for (int k = 0; k <= MAX_CODE; k++)
      repeat (GROUP) directed_q.push_back(vin_t'(k << SHIFT));
    for (int k = 1; k <= MAX_CODE; k++)
      repeat (GROUP) directed_q.push_back(vin_t'((k << SHIFT) - 1));
    repeat (GROUP) directed_q.push_back('1);
    directed_q.push_back('1);
    repeat (GROUP - 1) directed_q.push_back('0);

    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk);
      #2;
      check_value("vin_ready in reset", 32'(vin_ready), 32'd0);
      check_value("res_valid in reset", 32'(res_valid), 32'd0);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_value("vin_ready after reset", 32'(vin_ready), 32'd0);
    check_value("res_valid after reset", 32'(res_valid), 32'd0);

    while (groups_done < NUM_GROUPS)
    begin
      @(posedge clk);
      #2;
      if (in_fire)
        vin_valid = 1'b0;
      r = next_rand();
      if (!vin_valid && r[31:30] != 2'b00)
      begin
        vin       = pick_sample();
        vin_valid = 1'b1;
      end
      res_ready = r[28];

      @(negedge clk);
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT)
        fail_run($sformatf("Timeout: only %0d results after %0d cycles", groups_done, cycles));
      if (cycles == 1)
        check_value("vin_ready first cycle", 32'(vin_ready), 32'd1);

      in_fire  = vin_valid && vin_ready;
      out_fire = res_valid && res_ready;
      if (in_fire)
        model_q.push_back(vin);

      if (held_valid)
      begin
        check_value("res_valid held", 32'(res_valid), 32'd1);
        check_value("res held", 32'(res), 32'(held_res));
      end
      held_valid = res_valid && !res_ready;
      held_res   = res;

      // A result may only appear once a full group has been accepted
      if (res_valid)
      begin
        check_value("vin_ready with res_valid", 32'(vin_ready), 32'd0);
        check_value("accepted beats", 32'(model_q.size()), 32'(GROUP));
      end

      if (out_fire)
      begin
        exp_res = model_result();
        check_value("res.code", 32'(res.code), 32'(exp_res.code));
        check_value("res.overrange", 32'(res.overrange), 32'(exp_res.overrange));
        repeat (GROUP) void'(model_q.pop_front());
        groups_done = groups_done + 1;
      end
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: flist.f
source/adc_pkg.sv
source/adc_comparator_bank.sv
source/adc_thermo_encoder.sv
source/adc_settle_timer.sv
source/adc_sequencer.sv
source/adc_accumulator.sv
source/adc_flash_top.sv
verif/tb_adc_flash.sv

// File: Makefile
# Verilator flow for the flash ADC back end

VERILATOR ?= verilator
TOP       ?= tb_adc_flash
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
